//--- Makefile
TOP := rvCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
src/rvPkg.sv
src/rvDecoder.sv
src/rvImmGen.sv
src/rvRegFile.sv
src/rvAlu.sv
src/rvDataMem.sv
src/rvCore.sv
bench/rvCore_chk.sv
bench/rvCoreTb.sv

//--- bench/rvCoreTb.sv
`timescale 1ns/100ps

module rvCoreTb;
  import rvPkg::*;

  localparam word ResetPc   = 32'h80000000;
  localparam int  DmemWords = 16;
  localparam int  ProgWords = 64;
  localparam word Ebreak    = 32'h00100073;

  logic       clk;
  logic       rstN = 1'b0;
  word        inst = 32'h00000013;
  word        pc, nextPc, wbData, memAddr, memWdata;
  logic       halt, wbEn, memWe;
  logic [4:0] wbAddr;

  word   prog [ProgWords];
  word   mRegs [32];
  word   mMem [DmemWords];
  word   mPc;
  logic  mHalt;
  logic  running = 1'b0;
  int    pLen;
  string curTest;
  int    errors = 0;
  int    checks = 0;
  int    tests = 0;

  // Model prediction for the instruction in flight.
  word        eNext, eWbData, eMemAddr, eMemWdata;
  logic       eWbEn, eMemWe, eHaltNext;
  logic [4:0] eWbAddr;

  rvCore #(.ResetPc(ResetPc), .DmemWords(DmemWords)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic word encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                               logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opReg};
  endfunction

  function automatic word encI(opcodeE op, logic [11:0] imm, logic [4:0] rs1,
                               logic [2:0] f3, logic [4:0] rd);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
  endfunction

  function automatic word encB(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                               logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
  endfunction

  function automatic word encU(opcodeE op, logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, op};
  endfunction

  function automatic word encJ(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
  endfunction

  // Unused program slots hold an address-tagged ADDI to x0.
  function automatic word fetch(word addr);
    word off;
    off = (addr - ResetPc) >> 2;
    if (off < ProgWords) begin
      return prog[off];
    end
    return encI(opImm, off[11:0], 5'd0, 3'b000, 5'd0);
  endfunction

  // ISA-level execution of one word against the model state.
  function automatic void modelStep(input word w, output word nxt, output logic we,
      output logic [4:0] rd, output word wd, output logic me, output word ma,
      output word md, output logic hl);
    word a;
    word b;
    word iImm;
    word sImm;
    word bImm;
    word jImm;
    a = mRegs[w[19:15]];
    b = mRegs[w[24:20]];
    iImm = {{20{w[31]}}, w[31:20]};
    sImm = {{20{w[31]}}, w[31:25], w[11:7]};
    bImm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    jImm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    nxt = mPc + 32'd4;
    we = 1'b0;
    rd = w[11:7];
    wd = '0;
    me = 1'b0;
    ma = a + sImm;
    md = b;
    hl = mHalt;
    if (mHalt) begin
      nxt = mPc; // Frozen.
    end else begin
      case (w[6:0])
        opLui: begin
          we = 1'b1;
          wd = {w[31:12], 12'b0};
        end
        opAuipc: begin
          we = 1'b1;
          wd = mPc + {w[31:12], 12'b0};
        end
        opJal: begin
          we = 1'b1;
          wd = mPc + 32'd4;
          nxt = (mPc + jImm) & ~32'd1;
        end
        opJalr: begin
          we = 1'b1;
          wd = mPc + 32'd4;
          nxt = (a + iImm) & ~32'd1;
        end
        opBranch: begin
          if ((w[14:13] == 2'b00) && ((a == b) != w[12])) begin
            nxt = mPc + bImm;
          end
        end
        opLoad: begin
          we = (w[14:12] == 3'b010);
          wd = mMem[((a + iImm) >> 2) % DmemWords];
        end
        opStore: me = (w[14:12] == 3'b010);
        opImm: begin
          we = 1'b1;
          case (w[14:12])
            3'b000:  wd = a + iImm;
            3'b010:  wd = ($signed(a) < $signed(iImm)) ? 32'd1 : 32'd0;
            3'b100:  wd = a ^ iImm;
            3'b110:  wd = a | iImm;
            3'b111:  wd = a & iImm;
            default: we = 1'b0;
          endcase
        end
        opReg: begin
          we = 1'b1;
          case (w[14:12])
            3'b000:  wd = w[30] ? a - b : a + b;
            3'b010:  wd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  wd = a ^ b;
            3'b110:  wd = a | b;
            3'b111:  wd = a & b;
            default: we = 1'b0;
          endcase
        end
        opSystem: hl = (w == Ebreak);
        default: ;
      endcase
    end
  endfunction

  task automatic checkWord(input string what, input word exp, input word act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: test %s %s expected %h actual %h", curTest, what, exp, act);
    end
  endtask

  task automatic checkBit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: test %s %s expected %b actual %b", curTest, what, exp, act);
    end
  endtask

  task automatic checkRegAddr(input string what, input logic [4:0] exp, input logic [4:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error: test %s %s expected %0d actual %0d", curTest, what, exp, act);
    end
  endtask

  // Outputs are settled by the falling edge.
  always @(negedge clk) begin
    if (running) begin
      modelStep(inst, eNext, eWbEn, eWbAddr, eWbData, eMemWe, eMemAddr, eMemWdata,
                eHaltNext);
      checkWord("pc", mPc, pc);
      checkBit("halt", mHalt, halt);
      checkWord("nextPc", eNext, nextPc);
      checkBit("wbEn", eWbEn, wbEn);
      checkBit("memWe", eMemWe, memWe);
      if (eWbEn) begin
        checkRegAddr("wbAddr", eWbAddr, wbAddr);
        checkWord("wbData", eWbData, wbData);
      end
      if (eMemWe) begin
        checkWord("memAddr", eMemAddr, memAddr);
        checkWord("memWdata", eMemWdata, memWdata);
      end
    end
  end

  task automatic commitCycle();
    @(posedge clk);
    if (eWbEn && (eWbAddr != 5'd0)) begin
      mRegs[eWbAddr] = eWbData;
    end
    if (eMemWe) begin
      mMem[(eMemAddr >> 2) % DmemWords] = eMemWdata;
    end
    mPc = eNext;
    mHalt = eHaltNext;
  endtask

  task automatic resetCore();
    running = 1'b0;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      rstN <= 1'b0;
      if (i == 4) begin
        inst <= fetch(ResetPc);
      end else if (i[0]) begin
        inst <= encS(12'h010, 5'd1, 5'd0); // Write requests held off by reset.
      end else begin
        inst <= encI(opImm, 12'h7ff, 5'd1, 3'b000, 5'd7);
      end
      @(negedge clk);
      if (i > 0) begin
        checkWord("reset pc", ResetPc, pc);
        checkBit("reset halt", 1'b0, halt);
      end
      checkBit("reset wbEn", 1'b0, wbEn);
      checkBit("reset memWe", 1'b0, memWe);
    end
    @(posedge clk);
    rstN <= 1'b1;
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = '0;
    end
    mPc = ResetPc;
    mHalt = 1'b0;
    running = 1'b1;
  endtask

  task automatic clearProg();
    for (int i = 0; i < ProgWords; i++) begin
      prog[i] = encI(opImm, 12'(i), 5'd0, 3'b000, 5'd0);
    end
    pLen = 0;
  endtask

  task automatic emit(input word w);
    prog[pLen] = w;
    pLen++;
  endtask

  task automatic buildRandomProgram(input int count);
    logic [2:0] f3s [5] = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2};
    int         kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int i = 0; i < count; i++) begin
      kind = $urandom_range(0, 12);
      rd = 5'($urandom);
      rs1 = 5'($urandom);
      rs2 = 5'($urandom);
      if (kind < 5) begin
        emit(encI(opImm, 12'($urandom), rs1, f3s[kind], rd));
      end else if (kind < 10) begin
        emit(encR(7'b0000000, rs2, rs1, f3s[kind-5], rd));
      end else if (kind == 10) begin
        emit(encR(7'b0100000, rs2, rs1, 3'b000, rd)); // SUB.
      end else if (kind == 11) begin
        emit(encU(opLui, 20'($urandom), rd));
      end else begin
        emit(encU(opAuipc, 20'($urandom), rd));
      end
    end
    emit(Ebreak);
  endtask

  // Runs to halt, then offers a write and a store that must be dropped.
  task automatic runProgram(input string name, input int maxCycles);
    int cyc;
    int startErrors;
    curTest = name;
    startErrors = errors;
    resetCore();
    cyc = 0;
    @(negedge clk);
    while (!halt && (cyc < maxCycles)) begin
      commitCycle();
      inst <= fetch(mPc);
      cyc++;
      @(negedge clk);
    end
    if (!halt) begin
      errors++;
      $display("test %s did not halt within %0d cycles", name, maxCycles);
    end
    for (int i = 0; i < 4; i++) begin
      commitCycle();
      inst <= i[0] ? encS(12'h010, 5'd1, 5'd0) : encI(opImm, 12'h7ff, 5'd1, 3'b000, 5'd7);
    end
    commitCycle();
    running = 1'b0;
    tests++;
    if (errors == startErrors) begin
      $display("test %s ok, halted after %0d cycles", name, cyc);
    end else begin
      $display("test %s failed with %0d errors", name, errors - startErrors);
    end
  endtask

  initial begin
    void'($urandom(32'h66c2));
    for (int i = 0; i < DmemWords; i++) begin
      mMem[i] = '0;
    end

    clearProg();
    buildRandomProgram(50);
    runProgram("arith", 200);

    clearProg();
    emit(encI(opImm, 12'h040, 5'd0, 3'b000, 5'd1)); // Base address.
    emit(encU(opLui, 20'h12345, 5'd2));
    emit(encI(opImm, 12'h678, 5'd2, 3'b000, 5'd2));
    emit(encS(12'h000, 5'd2, 5'd1));
    emit(encS(12'h004, 5'd1, 5'd1));
    emit(encI(opImm, 12'(DmemWords * 4), 5'd1, 3'b000, 5'd3)); // One full wrap up.
    emit(encI(opLoad, 12'h000, 5'd3, 3'b010, 5'd4));
    emit(encI(opLoad, 12'h004, 5'd1, 3'b010, 5'd5));
    emit(encS(12'hff8, 5'd4, 5'd1));
    emit(encI(opLoad, 12'hff8, 5'd1, 3'b010, 5'd6));
    emit(Ebreak);
    runProgram("memory", 100);

    clearProg();
    emit(encI(opImm, 12'd5, 5'd0, 3'b000, 5'd1));
    emit(encI(opImm, 12'd5, 5'd0, 3'b000, 5'd2));
    emit(encB(13'd8, 5'd2, 5'd1, 3'b000)); // Taken BEQ.
    emit(encI(opImm, 12'd1, 5'd0, 3'b000, 5'd3));
    emit(encB(13'd8, 5'd2, 5'd1, 3'b001)); // BNE falls through.
    emit(encJ(21'd8, 5'd4));
    emit(encI(opImm, 12'd2, 5'd0, 3'b000, 5'd3));
    emit(encU(opAuipc, 20'd0, 5'd5));
    emit(encI(opJalr, 12'd13, 5'd5, 3'b000, 5'd6)); // Odd target.
    emit(encI(opImm, 12'd3, 5'd0, 3'b000, 5'd3));
    emit(encB(13'd8, 5'd1, 5'd3, 3'b001)); // Taken BNE.
    emit(encI(opImm, 12'd4, 5'd0, 3'b000, 5'd3));
    emit(encB(13'd8, 5'd0, 5'd1, 3'b000));
    emit(Ebreak);
    runProgram("control", 100);

    clearProg();
    emit(encI(opImm, 12'h055, 5'd0, 3'b000, 5'd0));
    emit(encI(opImm, 12'h123, 5'd0, 3'b000, 5'd1));
    emit(encR(7'b0000000, 5'd0, 5'd1, 3'b000, 5'd2));
    emit(encR(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd3));
    emit(Ebreak);
    runProgram("x0", 100);

    clearProg();
    emit(encI(opImm, 12'd7, 5'd0, 3'b000, 5'd1));
    emit(Ebreak);
    emit(encI(opImm, 12'd9, 5'd0, 3'b000, 5'd2)); // Never reached.
    runProgram("ebreak", 100);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- bench/rvCore_chk.sv
`timescale 1ns/100ps

module rvCoreChk (
  input logic       clk,
  input logic       rstN,
  input rvPkg::word pc,
  input logic       halt,
  input logic       ebreak,
  input logic       wbEn,
  input logic       memWe
);
  import rvPkg::*;

  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else $error("pc %h is not word aligned", pc);

  // Halt is sticky and freezes the PC.
  haltHolds: assert property (@(posedge clk) disable iff (!rstN)
    halt |=> halt && $stable(pc))
    else $error("halt dropped or pc moved while halted");

  // EBREAK halts at the next edge and writes stop.
  haltOnEbreak: assert property (@(posedge clk) disable iff (!rstN)
    ebreak |=> halt && !wbEn && !memWe)
    else $error("no halt or a write after EBREAK");

endmodule

bind rvCore rvCoreChk chk (
  .clk(clk), .rstN(rstN), .pc(pc), .halt(halt), .ebreak(ebreak), .wbEn(wbEn),
  .memWe(memWe)
);

//--- src/rvAlu.sv
`timescale 1ns/100ps

module rvAlu (
  input  rvPkg::word   a,
  input  rvPkg::word   b,
  input  rvPkg::aluOpE aluOp,
  output rvPkg::word   result,
  output logic         equal
);
  import rvPkg::*;

  word sum;
  word diff;

  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    case (aluOp)
      aluAdd:   result = sum;
      aluSub:   result = diff;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluXor:   result = a ^ b;
      aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
      aluPassB: result = b;
      default:  result = sum;
    endcase
  end

  // Branch condition flag.
  assign equal = (a == b);

endmodule

//--- src/rvCore.sv
`timescale 1ns/100ps

module rvCore #(
  parameter rvPkg::word ResetPc   = 32'h80000000,
  parameter int         DmemWords = 256
) (
  input  logic       clk,
  input  logic       rstN,
  input  rvPkg::word inst,
  output rvPkg::word pc,
  output rvPkg::word nextPc,
  output logic       halt,
  output logic       wbEn,
  output logic [4:0] wbAddr,
  output rvPkg::word wbData,
  output logic       memWe,
  output rvPkg::word memAddr,
  output rvPkg::word memWdata
);
  import rvPkg::*;

  immTypeE instType;
  aluOpE   aluOp;
  wbSelE   wbSel;
  logic    regWrite, memWrite, aluASel, aluBSel;
  logic    jump, branch, branchNe, ebreak;
  logic    equal, taken, commit;
  word     imm, rdata1, rdata2, aluA, aluB, aluResult, memRdata, snpc;

  rvDecoder decoder (
    .inst(inst), .instType(instType), .regWrite(regWrite), .memWe(memWrite),
    .aluASel(aluASel), .aluBSel(aluBSel), .jump(jump), .branch(branch),
    .branchNe(branchNe), .ebreak(ebreak), .wbSel(wbSel), .aluOp(aluOp)
  );

  rvImmGen immGen (.inst(inst), .instType(instType), .imm(imm));

  rvRegFile regFile (
    .clk(clk), .rstN(rstN), .wen(wbEn), .waddr(wbAddr),
    .raddr1(inst[19:15]), .raddr2(inst[24:20]), .wdata(wbData),
    .rdata1(rdata1), .rdata2(rdata2)
  );

  assign aluA = aluASel ? pc : rdata1;
  assign aluB = aluBSel ? imm : rdata2;

  rvAlu alu (.a(aluA), .b(aluB), .aluOp(aluOp), .result(aluResult), .equal(equal));

  rvDataMem #(.DmemWords(DmemWords)) dataMem (
    .clk(clk), .we(memWe), .addr(memAddr), .wdata(memWdata), .rdata(memRdata)
  );

  // Writes only outside reset and before halt.
  assign commit   = rstN && !halt;
  assign wbEn     = regWrite && commit;
  assign memWe    = memWrite && commit;
  assign wbAddr   = inst[11:7];
  assign memAddr  = aluResult;
  assign memWdata = rdata2;

  assign snpc = pc + 32'd4;

  always_comb begin
    case (wbSel)
      wbMem:   wbData = memRdata;
      wbLink:  wbData = snpc;
      default: wbData = aluResult;
    endcase
  end

  assign taken = branch && (equal != branchNe);

  always_comb begin
    if (halt) begin
      nextPc = pc; // Frozen until reset.
    end else if (jump) begin
      nextPc = {aluResult[31:1], 1'b0};
    end else if (taken) begin
      nextPc = pc + imm;
    end else begin
      nextPc = snpc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc   <= ResetPc;
      halt <= 1'b0;
    end else begin
      pc <= nextPc;
      if (ebreak) begin
        halt <= 1'b1; // Sticky.
      end
    end
  end

endmodule

//--- src/rvDataMem.sv
`timescale 1ns/100ps

module rvDataMem #(
  parameter int DmemWords = 256
) (
  input  logic       clk,
  input  logic       we,
  input  rvPkg::word addr,
  input  rvPkg::word wdata,
  output rvPkg::word rdata
);
  import rvPkg::*;

  localparam int IdxBits = $clog2(DmemWords);

  word                mem [DmemWords];
  logic [IdxBits-1:0] idx;

  assign idx = addr[IdxBits+1:2]; // Wraps modulo depth.

  always_ff @(posedge clk) begin
    if (we) begin
      mem[idx] <= wdata;
    end
  end

  assign rdata = mem[idx];

endmodule

//--- src/rvDecoder.sv
`timescale 1ns/100ps

module rvDecoder (
  input  rvPkg::word     inst,
  output rvPkg::immTypeE instType,
  output logic           regWrite,
  output logic           memWe,
  output logic           aluASel,
  output logic           aluBSel,
  output logic           jump,
  output logic           branch,
  output logic           branchNe,
  output logic           ebreak,
  output rvPkg::wbSelE   wbSel,
  output rvPkg::aluOpE   aluOp
);
  import rvPkg::*;

  opcodeE     opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcodeE'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    instType = immI;
    regWrite = 1'b0;
    memWe    = 1'b0;
    aluASel  = 1'b0;
    aluBSel  = 1'b0;
    jump     = 1'b0;
    branch   = 1'b0;
    branchNe = 1'b0;
    ebreak   = 1'b0;
    wbSel    = wbAlu;
    aluOp    = aluAdd;
    case (opcode)
      opLui: begin
        instType = immU;
        regWrite = 1'b1;
        aluBSel  = 1'b1;
        aluOp    = aluPassB; // Immediate straight through.
      end
      opAuipc: begin
        instType = immU;
        regWrite = 1'b1;
        aluASel  = 1'b1;
        aluBSel  = 1'b1;
      end
      opJal: begin
        instType = immJ;
        regWrite = 1'b1;
        jump     = 1'b1;
        aluASel  = 1'b1;
        aluBSel  = 1'b1;
        wbSel    = wbLink;
      end
      opJalr: begin
        regWrite = (funct3 == 3'b000);
        jump     = (funct3 == 3'b000);
        aluBSel  = 1'b1;
        wbSel    = wbLink;
      end
      opBranch: begin
        instType = immB;
        branch   = (funct3 == 3'b000) || (funct3 == 3'b001); // BEQ or BNE.
        branchNe = funct3[0];
        aluOp    = aluSub;
      end
      opLoad: begin
        regWrite = (funct3 == 3'b010); // Words only.
        aluBSel  = 1'b1;
        wbSel    = wbMem;
      end
      opStore: begin
        instType = immS;
        memWe    = (funct3 == 3'b010);
        aluBSel  = 1'b1;
      end
      opImm: begin
        aluBSel  = 1'b1;
        regWrite = 1'b1;
        case (funct3)
          3'b000:  aluOp = aluAdd;
          3'b010:  aluOp = aluSlt;
          3'b100:  aluOp = aluXor;
          3'b110:  aluOp = aluOr;
          3'b111:  aluOp = aluAnd;
          default: regWrite = 1'b0; // Shifts and SLTIU.
        endcase
      end
      opReg: begin
        regWrite = 1'b1;
        case ({funct7, funct3})
          {funct7Base, 3'b000}: aluOp = aluAdd;
          {funct7Alt, 3'b000}:  aluOp = aluSub;
          {funct7Base, 3'b010}: aluOp = aluSlt;
          {funct7Base, 3'b100}: aluOp = aluXor;
          {funct7Base, 3'b110}: aluOp = aluOr;
          {funct7Base, 3'b111}: aluOp = aluAnd;
          default:              regWrite = 1'b0;
        endcase
      end
      opSystem: ebreak = (inst == EbreakWord);
      default: ; // No-op.
    endcase
  end

endmodule

//--- src/rvImmGen.sv
`timescale 1ns/100ps

module rvImmGen (
  input  rvPkg::word     inst,
  input  rvPkg::immTypeE instType,
  output rvPkg::word     imm
);
  import rvPkg::*;

  always_comb begin
    case (instType)
      immI: imm = {{20{inst[31]}}, inst[31:20]};
      immS: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      immB: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      immU: imm = {inst[31:12], 12'b0};
      immJ: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

//--- src/rvPkg.sv
package rvPkg;

  typedef logic [31:0] word;

  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opReg    = 7'b0110011,
    opSystem = 7'b1110011
  } opcodeE;

  typedef enum logic [3:0] {
    aluAdd   = 4'd0,
    aluSub   = 4'd1,
    aluAnd   = 4'd2,
    aluOr    = 4'd3,
    aluXor   = 4'd4,
    aluSlt   = 4'd5,
    aluPassB = 4'd6
  } aluOpE;

  typedef enum logic [2:0] {
    immI = 3'd0,
    immS = 3'd1,
    immB = 3'd2,
    immU = 3'd3,
    immJ = 3'd4
  } immTypeE;

  typedef enum logic [1:0] {
    wbMem  = 2'd0,
    wbAlu  = 2'd1,
    wbLink = 2'd2
  } wbSelE;

  // Full encoding of the only supported SYSTEM instruction.
  localparam word EbreakWord = 32'h00100073;

  localparam logic [6:0] funct7Base = 7'b0000000;
  localparam logic [6:0] funct7Alt  = 7'b0100000;

endpackage

//--- src/rvRegFile.sv
`timescale 1ns/100ps

module rvRegFile (
  input  logic       clk,
  input  logic       rstN,
  input  logic       wen,
  input  logic [4:0] waddr,
  input  logic [4:0] raddr1,
  input  logic [4:0] raddr2,
  input  rvPkg::word wdata,
  output rvPkg::word rdata1,
  output rvPkg::word rdata2
);
  import rvPkg::*;

  word regs [32];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata; // x0 never written.
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule
